//--- logic/rsPkg.sv
`default_nettype none

package rsPkg;

    localparam int numEntries      = 16;
    localparam int entryIndexWidth = 4;
    localparam int tagWidth        = 7;
    localparam int dataWidth       = 32;
    localparam int numWakeBuses    = 4; // ALU 0, MUL 1, DIV 2, load 3

    typedef logic [tagWidth-1:0]  physTag;
    typedef logic [dataWidth-1:0] regData;

    typedef struct packed {
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [3:0] aluOp;
        logic       memRead; // load ops derive from this
        logic       memWrite;
    } uopCtrl;

    typedef struct packed {
        physTag tag;
        regData data;
        logic   ready; // data holds the value
    } srcOperand;

    typedef struct packed {
        uopCtrl      ctrl;
        logic [31:0] pc;
        physTag      destTag;
        logic [31:0] immediate;
        srcOperand   src1;
        srcOperand   src2;
    } dispatchReq;

    typedef struct packed {
        logic   valid; // one-cycle broadcast
        physTag tag;
        regData data;
    } wakeBus;

    typedef struct packed {
        uopCtrl      ctrl;
        logic [31:0] pc;
        physTag      destTag;
        logic [31:0] immediate;
        regData      src1Data;
        regData      src2Data;
    } issueBundle;

endpackage

`default_nettype wire

//--- logic/lowestFirstPicker.sv
`timescale 1ns/1ps
`default_nettype none

module lowestFirstPicker #(
    parameter int width      = rsPkg::numEntries,
    parameter int indexWidth = $clog2(width)
) (
    input  logic [width-1:0]      requests,
    output logic [width-1:0]      grantOneHot,
    output logic [indexWidth-1:0] grantIndex,
    output logic                  anyGrant
);

    always_comb begin
        grantOneHot = '0;
        grantIndex  = '0;
        anyGrant    = 1'b0;
        for (int i = width - 1; i >= 0; i--) begin // downward, lowest hit lands last
            if (requests[i]) begin
                grantOneHot    = '0;
                grantOneHot[i] = 1'b1;
                grantIndex     = indexWidth'(i);
                anyGrant       = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/operandCapture.sv
`timescale 1ns/1ps
`default_nettype none

// Bypass for a source operand whose producer broadcasts in the dispatch
// cycle itself, so the entry is written already holding the value.
module operandCapture (
    input  rsPkg::srcOperand                          source,
    input  rsPkg::wakeBus [rsPkg::numWakeBuses-1:0]   wakeBuses,
    output rsPkg::srcOperand                          resolved
);

    always_comb begin
        resolved = source;
        if (!source.ready) begin
            // highest bus first so bus 0 overrides on a double match
            for (int b = rsPkg::numWakeBuses - 1; b >= 0; b--) begin
                if (wakeBuses[b].valid && wakeBuses[b].tag == source.tag) begin
                    resolved.data  = wakeBuses[b].data;
                    resolved.ready = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/rsEntryArray.sv
`timescale 1ns/1ps
`default_nettype none

module rsEntryArray (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  writeEnable,
    input  logic [rsPkg::numEntries-1:0]          writeOneHot,
    input  rsPkg::dispatchReq                     writeReq,
    input  rsPkg::wakeBus [rsPkg::numWakeBuses-1:0] wakeBuses,
    input  logic                                  takeEnable,
    input  logic [rsPkg::numEntries-1:0]          takeOneHot,
    input  logic [rsPkg::entryIndexWidth-1:0]     takeIndex,
    output logic [rsPkg::numEntries-1:0]          freeMask,
    output logic [rsPkg::numEntries-1:0]          readyMask,
    output rsPkg::issueBundle                     takenBundle
);

    logic [rsPkg::numEntries-1:0] occupied;
    rsPkg::dispatchReq            entries [rsPkg::numEntries];

    // occupancy bookkeeping
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            occupied <= '0;
        end else begin
            for (int e = 0; e < rsPkg::numEntries; e++) begin
                if (writeEnable && writeOneHot[e]) begin
                    occupied[e] <= 1'b1;
                end else if (takeEnable && takeOneHot[e]) begin
                    occupied[e] <= 1'b0; // entry leaves for the slice
                end
            end
        end
    end

    // payload write and wakeup snooping
    always_ff @(posedge clk) begin
        for (int e = 0; e < rsPkg::numEntries; e++) begin
            if (writeEnable && writeOneHot[e]) begin
                entries[e] <= writeReq; // sources already bypass-resolved
            end else if (occupied[e]) begin
                for (int b = rsPkg::numWakeBuses - 1; b >= 0; b--) begin
                    if (wakeBuses[b].valid && !entries[e].src1.ready
                            && entries[e].src1.tag == wakeBuses[b].tag) begin
                        entries[e].src1.data  <= wakeBuses[b].data;
                        entries[e].src1.ready <= 1'b1;
                    end
                    if (wakeBuses[b].valid && !entries[e].src2.ready
                            && entries[e].src2.tag == wakeBuses[b].tag) begin
                        entries[e].src2.data  <= wakeBuses[b].data;
                        entries[e].src2.ready <= 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int e = 0; e < rsPkg::numEntries; e++) begin
            readyMask[e] = occupied[e] && entries[e].src1.ready && entries[e].src2.ready;
        end
    end

    assign freeMask = ~occupied;

    always_comb begin
        takenBundle.ctrl      = entries[takeIndex].ctrl;
        takenBundle.pc        = entries[takeIndex].pc;
        takenBundle.destTag   = entries[takeIndex].destTag;
        takenBundle.immediate = entries[takeIndex].immediate;
        takenBundle.src1Data  = entries[takeIndex].src1.data;
        takenBundle.src2Data  = entries[takeIndex].src2.data; // tags stay behind
    end

endmodule

`default_nettype wire

//--- logic/issueSlice.sv
`timescale 1ns/1ps
`default_nettype none

module issueSlice #(
    parameter type payloadType = logic
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       inValid,
    output logic       inReady,
    input  payloadType inPayload,
    output logic       outValid,
    input  logic       outReady,
    output payloadType outPayload
);

    assign inReady = !outValid || outReady; // refill while draining

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            outPayload <= inPayload; // held while stalled
        end
    end

endmodule

`default_nettype wire

//--- logic/reservationStation.sv
`timescale 1ns/1ps
`default_nettype none

module reservationStation (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    dispatchValid,
    output logic                                    dispatchReady,
    input  rsPkg::dispatchReq                       dispatch,
    input  rsPkg::wakeBus [rsPkg::numWakeBuses-1:0] wakeBuses,
    output logic                                    issueValid,
    input  logic                                    issueReady,
    output rsPkg::issueBundle                       issue
);

    rsPkg::srcOperand                  src1Resolved;
    rsPkg::srcOperand                  src2Resolved;
    rsPkg::dispatchReq                 writeReq;
    logic                              writeEnable;
    logic [rsPkg::numEntries-1:0]      freeMask;
    logic [rsPkg::numEntries-1:0]      readyMask;
    logic [rsPkg::numEntries-1:0]      allocOneHot;
    logic [rsPkg::numEntries-1:0]      issueOneHot;
    logic [rsPkg::entryIndexWidth-1:0] issueIndex;
    logic                              issueAny;
    logic                              issueTake;
    logic                              sliceInReady;
    rsPkg::issueBundle                 takenBundle;

    operandCapture u_capture1 (
        .source    (dispatch.src1),
        .wakeBuses (wakeBuses),
        .resolved  (src1Resolved)
    );

    operandCapture u_capture2 (
        .source    (dispatch.src2),
        .wakeBuses (wakeBuses),
        .resolved  (src2Resolved)
    );

    always_comb begin
        writeReq      = dispatch;
        writeReq.src1 = src1Resolved;
        writeReq.src2 = src2Resolved;
    end

    lowestFirstPicker #(.width(rsPkg::numEntries)) u_freePicker (
        .requests    (freeMask),
        .grantOneHot (allocOneHot),
        .grantIndex  (),
        .anyGrant    (dispatchReady) // any free entry
    );

    lowestFirstPicker #(.width(rsPkg::numEntries)) u_issuePicker (
        .requests    (readyMask),
        .grantOneHot (issueOneHot),
        .grantIndex  (issueIndex),
        .anyGrant    (issueAny)
    );

    assign writeEnable = dispatchValid && dispatchReady;
    assign issueTake   = issueAny && sliceInReady;

    rsEntryArray u_array (
        .clk         (clk),
        .reset       (reset),
        .writeEnable (writeEnable),
        .writeOneHot (allocOneHot),
        .writeReq    (writeReq),
        .wakeBuses   (wakeBuses),
        .takeEnable  (issueTake),
        .takeOneHot  (issueOneHot),
        .takeIndex   (issueIndex),
        .freeMask    (freeMask),
        .readyMask   (readyMask),
        .takenBundle (takenBundle)
    );

    issueSlice #(.payloadType(rsPkg::issueBundle)) u_slice (
        .clk        (clk),
        .reset      (reset),
        .inValid    (issueAny),
        .inReady    (sliceInReady),
        .inPayload  (takenBundle),
        .outValid   (issueValid),
        .outReady   (issueReady),
        .outPayload (issue)
    );

endmodule

`default_nettype wire

//--- verification/rsTbUtil.svh
`ifndef RS_TB_UTIL_SVH
`define RS_TB_UTIL_SVH

// immediate check wrapped as one statement
`define checkEqual(what, expVal, actVal) \
    begin \
        assert ((expVal) === (actVal)) else begin \
            $display("Mismatch in %s, %s: expected %h, actual %h", \
                testName, what, (expVal), (actVal)); \
            errorCount++; \
        end \
    end

logic [15:0] lfsrState = 16'd12191;
string       testName;
int          errorCount;
int          errorsAtStart;
int          passedTests;
int          failedTests;

// 16-bit Galois LFSR stepped once per bit
function automatic logic [31:0] randomBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
        value     = {value[30:0], lfsrState[0]};
        lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
    end
    return value;
endfunction

task automatic startTest(input string name);
    testName      = name;
    errorsAtStart = errorCount;
endtask

task automatic finishTest();
    if (errorCount == errorsAtStart) begin
        passedTests++;
        $display("PASS %s", testName);
    end else begin
        failedTests++;
        $display("FAIL %s with %0d errors", testName, errorCount - errorsAtStart);
    end
endtask

`endif

//--- verification/rsTb.sv
`timescale 1ns/1ps
`default_nettype none

module rsTb;

    localparam int timeoutCycles = 200;

    logic                                    clk;
    logic                                    reset;
    logic                                    dispatchValid;
    logic                                    dispatchReady;
    rsPkg::dispatchReq                       dispatch;
    rsPkg::wakeBus [rsPkg::numWakeBuses-1:0] wakeBuses;
    logic                                    issueValid;
    logic                                    issueReady;
    rsPkg::issueBundle                       issue;
    rsPkg::issueBundle                       expectQ [$]; // outstanding issues
    logic                                    inOrder;
    int                                      issueCount;
    logic [31:0]                             nextPc;

    `include "rsTbUtil.svh"

    reservationStation u_dut (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (!reset && issueValid && issueReady) begin
            matchIssue(issue); // pre-edge output values
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        issueValid && !issueReady |=> issueValid && $stable(issue))
    else begin
        $display("Issue output changed while stalled in %s", testName);
        errorCount++;
    end

    function automatic rsPkg::dispatchReq randomOp(input logic ready1, input logic ready2);
        rsPkg::dispatchReq op;
        op.ctrl       = rsPkg::uopCtrl'(randomBits(16));
        op.pc         = nextPc; // unique per op
        op.destTag    = rsPkg::physTag'(randomBits(7));
        op.immediate  = randomBits(32);
        op.src1.tag   = rsPkg::physTag'(randomBits(7));
        op.src1.data  = randomBits(32);
        op.src1.ready = ready1;
        op.src2.tag   = rsPkg::physTag'(randomBits(7));
        op.src2.data  = randomBits(32);
        op.src2.ready = ready2;
        nextPc        = nextPc + 32'd4;
        return op;
    endfunction

    task automatic expectIssue(input rsPkg::dispatchReq op, input rsPkg::regData d1,
                               input rsPkg::regData d2);
        expectQ.push_back(rsPkg::issueBundle'{op.ctrl, op.pc, op.destTag, op.immediate, d1, d2});
    endtask

    task automatic matchIssue(input rsPkg::issueBundle got);
        int hit;
        hit = -1;
        foreach (expectQ[i]) begin
            if (hit < 0 && expectQ[i].pc == got.pc) begin
                hit = i;
            end
        end
        issueCount++;
        if (hit < 0) begin
            $display("Unexpected or repeated issue of pc %h in %s", got.pc, testName);
            errorCount++;
        end else begin
            if (inOrder) `checkEqual("issue order", 0, hit)
            `checkEqual("issued bundle", expectQ[hit], got)
            expectQ.delete(hit);
        end
    endtask

    task automatic dispatchOp(input rsPkg::dispatchReq op);
        int waited;
        waited        = 0;
        dispatch      = op;
        dispatchValid = 1'b1;
        while (!dispatchReady && waited < timeoutCycles) begin
            @(negedge clk);
            waited++;
        end
        if (!dispatchReady) begin
            $display("Timed out waiting for a free entry in %s", testName);
            errorCount++;
        end
        @(negedge clk);
        dispatchValid = 1'b0;
    endtask

    task automatic broadcast(input int bus, input rsPkg::physTag tag, input rsPkg::regData data);
        wakeBuses[bus] = rsPkg::wakeBus'{1'b1, tag, data};
        @(negedge clk);
        wakeBuses[bus].valid = 1'b0;
    endtask

    task automatic waitIssued(input int target);
        int waited;
        waited = 0;
        while (issueCount < target && waited < timeoutCycles) begin
            @(negedge clk);
            waited++;
        end
        if (issueCount < target) begin
            $display("Timed out in %s with %0d issues missing", testName, target - issueCount);
            errorCount++;
        end
    endtask

    task automatic resetDut();
        reset         = 1'b1;
        dispatchValid = 1'b0;
        dispatch      = '0;
        wakeBuses     = '0;
        issueReady    = 1'b1;
        inOrder       = 1'b0;
        expectQ.delete();
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    endtask

    initial begin
        rsPkg::dispatchReq op;
        rsPkg::physTag     tag;
        rsPkg::regData     data;
        rsPkg::regData     waitData [rsPkg::numEntries];
        int                pick;
        int                sent;
        int                startCount;
        int                spanLeft;

        clk    = 1'b0;
        nextPc = 32'h0000_1000;
        resetDut();

        startTest("resetAndDirectIssue");
        `checkEqual("issueValid after reset", 1'b0, issueValid)
        `checkEqual("dispatchReady after reset", 1'b1, dispatchReady)
        op = randomOp(1'b1, 1'b1);
        expectIssue(op, op.src1.data, op.src2.data);
        dispatchOp(op);
        @(negedge clk);
        `checkEqual("issueValid one edge after dispatch", 1'b1, issueValid)
        waitIssued(issueCount + expectQ.size());
        finishTest();

        startTest("wakeupPerBus");
        for (int bus = 0; bus < rsPkg::numWakeBuses; bus++) begin
            op   = randomOp(1'b1, 1'b0);
            data = randomBits(32);
            expectIssue(op, op.src1.data, data);
            dispatchOp(op);
            @(negedge clk);
            `checkEqual("issueValid before wakeup", 1'b0, issueValid)
            broadcast(bus, op.src2.tag, data);
            waitIssued(issueCount + expectQ.size());
        end
        finishTest();

        startTest("dispatchBypass");
        op   = randomOp(1'b0, 1'b1);
        data = randomBits(32);
        expectIssue(op, data, op.src2.data);
        wakeBuses[3] = rsPkg::wakeBus'{1'b1, op.src1.tag, data}; // same cycle as dispatch
        dispatchOp(op);
        wakeBuses[3].valid = 1'b0;
        @(negedge clk);
        `checkEqual("issueValid after bypass dispatch", 1'b1, issueValid)
        waitIssued(issueCount + expectQ.size());
        finishTest();

        startTest("fullStation");
        tag = rsPkg::physTag'(randomBits(7));
        for (int i = 0; i < rsPkg::numEntries; i++) begin
            op          = randomOp(1'b1, 1'b0);
            op.src2.tag = rsPkg::physTag'(tag + i); // distinct tags
            waitData[i] = randomBits(32);
            expectIssue(op, op.src1.data, waitData[i]);
            dispatchOp(op);
        end
        `checkEqual("dispatchReady when full", 1'b0, dispatchReady)
        pick = int'(randomBits(4));
        broadcast(pick % rsPkg::numWakeBuses, rsPkg::physTag'(tag + pick), waitData[pick]);
        waitIssued(issueCount + 1);
        `checkEqual("dispatchReady after one issue", 1'b1, dispatchReady)
        op = randomOp(1'b1, 1'b1);
        expectIssue(op, op.src1.data, op.src2.data);
        dispatchOp(op);
        `checkEqual("dispatchReady after refill", 1'b0, dispatchReady) // only one was free
        for (int i = 0; i < rsPkg::numEntries; i++) begin
            if (i != pick) begin
                broadcast(i % rsPkg::numWakeBuses, rsPkg::physTag'(tag + i), waitData[i]);
            end
        end
        waitIssued(issueCount + expectQ.size());
        finishTest();

        startTest("lowestIndexOrder");
        resetDut();
        inOrder = 1'b1;
        tag     = rsPkg::physTag'(randomBits(7));
        data    = randomBits(32);
        for (int i = 0; i < 6; i++) begin
            op          = randomOp(1'b0, 1'b1);
            op.src1.tag = tag;
            expectIssue(op, data, op.src2.data);
            dispatchOp(op);
        end
        broadcast(1, tag, data);
        waitIssued(issueCount + 1);
        for (int i = 0; i < 5; i++) begin
            `checkEqual("issueValid in burst", 1'b1, issueValid)
            @(negedge clk);
        end
        waitIssued(issueCount + expectQ.size());
        finishTest();

        startTest("backPressure");
        resetDut();
        sent       = 0;
        spanLeft   = 0;
        startCount = issueCount;
        for (int cyc = 0; cyc < 150; cyc++) begin
            if (spanLeft == 0) begin
                issueReady = randomBits(1) == 32'd1;
                spanLeft   = 1 + int'(randomBits(3));
            end
            spanLeft--;
            // dispatchReady holds until the next edge, so the transfer is certain
            if (dispatchReady && randomBits(1) == 32'd1) begin
                op = randomOp(1'b1, 1'b1);
                expectIssue(op, op.src1.data, op.src2.data);
                dispatch      = op;
                dispatchValid = 1'b1;
                sent++;
            end else begin
                dispatchValid = 1'b0;
            end
            @(negedge clk);
        end
        dispatchValid = 1'b0;
        issueReady    = 1'b1;
        waitIssued(issueCount + expectQ.size());
        `checkEqual("issued count", sent, issueCount - startCount)
        finishTest();

        $display("Totals: %0d tests passed, %0d tests failed, %0d errors",
            passedTests, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+verification
logic/rsPkg.sv
logic/lowestFirstPicker.sv
logic/operandCapture.sv
logic/rsEntryArray.sv
logic/issueSlice.sv
logic/reservationStation.sv
verification/rsTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module rsTb -o rsSim
./obj_dir/rsSim > sim.log 2>&1
cat sim.log

if ! grep -qx "All tests passed" sim.log; then
    exit 1
fi
